// File: src.f
scuRegPkg.sv
scuIrqPkg.sv
cpuBusPort.sv
extEventSampler.sv
scuRegs.sv
scuTimers.sv
irqController.sv
cpuReadPort.sv
scuTop.sv
tbClock.sv
scuTb.sv

// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --assert -f src.f --top-module scuTb -o simv
	./obj_dir/simv | tee sim.log
	grep -q "Finished with no errors" sim.log

lint:
	verilator --lint-only --timing --assert -f src.f --top-module scuTb

clean:
	rm -rf obj_dir sim.log

// File: scuTb.sv
module scuTb;

	localparam logic [24:0] REG_BASE = 25'h1FE0000;
	localparam int ITER = 24;
	localparam int TIMER_RUNS = 3;
	localparam int CLK_PERIOD = 40;

	localparam logic [7:0] T0C = 8'h90;
	localparam logic [7:0] T1S = 8'h94;
	localparam logic [7:0] T1MD = 8'h98;
	localparam logic [7:0] IMS = 8'hA0;
	localparam logic [7:0] IST = 8'hA4;

	logic        CLK;
	logic        RST_N;
	logic        CE_R;
	logic        CE_F;
	logic [24:0] CA;
	logic [31:0] CDI;
	logic [3:0]  CDQM_N;
	logic        CCS2_N;
	logic        CRD_N;
	logic        CIVECF_N;
	logic        IRQV_N;
	logic        IRQH_N;
	logic        IRQS_N;
	logic        IRQ1_N;
	logic        MIREQ_N;
	logic [31:0] CDO;
	logic [3:0]  CIRL_N;

	// Reference model state
	logic [15:0] pend;
	logic [15:0] ims;
	integer      seed = 16978;
	int          checkCnt = 0;
	int          errCnt = 0;
	int          testErr = 0;

	tbClock #(.period(CLK_PERIOD), .resetCycles(4)) tbClock_i (.CLK(CLK), .RST_N(RST_N));

	scuTop #(.regBase(REG_BASE)) scuTop_i (
		.CLK(CLK), .RST_N(RST_N), .CE_R(CE_R), .CE_F(CE_F), .CA(CA), .CDI(CDI),
		.CDQM_N(CDQM_N), .CCS2_N(CCS2_N), .CRD_N(CRD_N), .CIVECF_N(CIVECF_N),
		.IRQV_N(IRQV_N), .IRQH_N(IRQH_N), .IRQS_N(IRQS_N), .IRQ1_N(IRQ1_N),
		.MIREQ_N(MIREQ_N), .CDO(CDO), .CIRL_N(CIRL_N)
	);

	// CE_R and CE_F on alternate cycles
	always @(posedge CLK) begin
		CE_R <= ~CE_R;
		CE_F <= CE_R;
	end

	function automatic logic [3:0] topLevel(input logic [15:0] p, input logic [15:0] m);
		logic [15:0] a;
		a = p & ~m;
		if (a[0]) return 4'd15;
		else if (a[1]) return 4'd14;
		else if (a[2]) return 4'd13;
		else if (a[3]) return 4'd12;
		else if (a[4]) return 4'd11;
		else if (a[6]) return 4'd9;
		else if (a[7]) return 4'd8;
		else if (a[13]) return 4'd2;
		return 4'd0;
	endfunction

	function automatic logic [7:0] vectorOf(input logic [3:0] lvl);
		case (lvl)
			4'd15: return 8'h40;
			4'd14: return 8'h41;
			4'd13: return 8'h42;
			4'd12: return 8'h43;
			4'd11: return 8'h44;
			4'd9:  return 8'h46;
			4'd8:  return 8'h47;
			4'd2:  return 8'h4D;
			default: return 8'h00;
		endcase
	endfunction

	function automatic logic [15:0] bitOfLevel(input logic [3:0] lvl);
		case (lvl)
			4'd15: return 16'h0001;
			4'd14: return 16'h0002;
			4'd13: return 16'h0004;
			4'd12: return 16'h0008;
			4'd11: return 16'h0010;
			4'd9:  return 16'h0040;
			4'd8:  return 16'h0080;
			4'd2:  return 16'h2000;
			default: return 16'h0000;
		endcase
	endfunction

	task automatic compareValue(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checkCnt++;
		assert (got === exp) else begin
			$display("ERR %s: got %h, expected %h", name, got, exp);
			errCnt++;
			testErr++;
		end
	endtask

	task automatic reportTest(input string name);
		if (testErr == 0)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, testErr);
		testErr = 0;
	endtask

	task automatic waitEdges(input int n);
		repeat (n) @(posedge CLK);
	endtask

	task automatic cpuWrite(input logic [7:0] off, input logic [31:0] data);
		CA <= REG_BASE + {17'd0, off};
		CDI <= data;
		CDQM_N <= 4'h0;
		CCS2_N <= 1'b0;
		waitEdges(4);
		CDQM_N <= 4'hF;
		CCS2_N <= 1'b1;
		waitEdges(2);
	endtask

	task automatic cpuRead(input logic [7:0] off, output logic [31:0] data);
		CA <= REG_BASE + {17'd0, off};
		CCS2_N <= 1'b0;
		CRD_N <= 1'b0;
		waitEdges(4);
		data = CDO;
		CRD_N <= 1'b1;
		CCS2_N <= 1'b1;
		waitEdges(2);
	endtask

	task automatic vectorFetch(input logic [3:0] code, output logic [7:0] vec);
		CA <= {21'd0, code};
		CIVECF_N <= 1'b0;
		CRD_N <= 1'b0;
		waitEdges(4);
		vec = CDO[7:0];
		CRD_N <= 1'b1;
		CIVECF_N <= 1'b1;
		waitEdges(2);
	endtask

	// sel bits: V-blank, H-blank, sound, sprite, system manager
	task automatic pulseEvents(input logic [4:0] sel);
		IRQV_N <= ~sel[0];
		IRQH_N <= ~sel[1];
		IRQS_N <= ~sel[2];
		IRQ1_N <= ~sel[3];
		MIREQ_N <= ~sel[4];
		waitEdges(2);
		IRQV_N <= 1'b1;
		IRQH_N <= 1'b1;
		IRQS_N <= 1'b1;
		IRQ1_N <= 1'b1;
		MIREQ_N <= 1'b1;
		waitEdges(2);
		if (sel[0])
			pend[1:0] = 2'b11;
		if (sel[1])
			pend[2] = 1'b1;
		if (sel[2])
			pend[6] = 1'b1;
		if (sel[3])
			pend[13] = 1'b1;
		if (sel[4])
			pend[7] = 1'b1;
	endtask

	// An all-ones IST write clears nothing but lets the level relatch
	task automatic refreshLevel();
		cpuWrite(IST, 32'h0000_FFFF);
		waitEdges(4);
	endtask

	initial begin
		#((64 * ITER + 3000) * CLK_PERIOD);
		$display("Timeout: the tests did not complete in time");
		$display("Finished with errors");
		$finish;
	end

	initial begin : mainSeq
		logic [31:0] r;
		logic [31:0] d;
		logic [7:0]  vec;
		logic [4:0]  sel;
		logic [3:0]  lvl;
		logic [2:0]  t0c;
		CE_R = 1'b0;
		CE_F = 1'b0;
		CA = '0;
		CDI = '0;
		CDQM_N = 4'hF;
		CCS2_N = 1'b1;
		CRD_N = 1'b1;
		CIVECF_N = 1'b1;
		IRQV_N = 1'b1;
		IRQH_N = 1'b1;
		IRQS_N = 1'b1;
		IRQ1_N = 1'b1;
		MIREQ_N = 1'b1;
		pend = '0;
		ims = 16'hBFFF;
		wait (RST_N);
		waitEdges(2);

		for (int it = 0; it < ITER; it++) begin
			r = $random(seed);
			pulseEvents(r[4:0]);
			cpuRead(IST, d);
			compareValue("CDO", d, {16'd0, pend});
			reportTest("status capture");

			r = $random(seed);
			cpuWrite(IST, r);
			pend = pend & r[15:0];
			cpuRead(IST, d);
			compareValue("CDO", d, {16'd0, pend});
			reportTest("status clearing");

			r = $random(seed);
			cpuWrite(IMS, r);
			ims = r[15:0] & 16'hBFFF;
			r = $random(seed);
			pulseEvents(r[4:0]);
			refreshLevel();
			compareValue("CIRL_N", {28'd0, CIRL_N}, {28'd0, ~topLevel(pend, ims)});
			reportTest("priority level");

			cpuWrite(IMS, 32'h0);
			ims = '0;
			r = $random(seed);
			sel = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
			pulseEvents(sel);
			refreshLevel();
			lvl = topLevel(pend, ims);
			compareValue("CIRL_N", {28'd0, CIRL_N}, {28'd0, ~lvl});
			vectorFetch(lvl, vec);
			compareValue("CDO[7:0]", {24'd0, vec}, {24'd0, vectorOf(lvl)});
			pend = pend & ~bitOfLevel(lvl);
			compareValue("CIRL_N", {28'd0, CIRL_N}, {28'd0, ~topLevel(pend, ims)});
			cpuRead(IST, d);
			compareValue("CDO", d, {16'd0, pend});
			reportTest("vector fetch");
		end

		for (int run = 0; run < TIMER_RUNS; run++) begin
			r = $random(seed);
			t0c = r[2:0];
			cpuWrite(T1MD, 32'h1);
			cpuWrite(T0C, {29'd0, t0c});
			cpuWrite(IST, 32'h0);
			pend = '0;
			pulseEvents(5'b00001);
			repeat (t0c) pulseEvents(5'b00010);
			cpuRead(IST, d);
			compareValue("IST[3]", {31'd0, d[3]}, 32'd0);
			pulseEvents(5'b00010);
			cpuRead(IST, d);
			compareValue("IST[3]", {31'd0, d[3]}, 32'd1);
			cpuWrite(T1MD, 32'h0);
			cpuWrite(IST, 32'h0);
			pend = '0;
			reportTest("timer 0");
		end

		cpuWrite(T1S, 32'h0);
		cpuWrite(T1MD, 32'h1);
		cpuWrite(IST, 32'h0);
		pulseEvents(5'b00010);
		waitEdges(16);
		cpuRead(IST, d);
		compareValue("IST[4]", {31'd0, d[4]}, 32'd1);
		cpuWrite(T1MD, 32'h0);
		cpuWrite(IST, 32'h0);
		pulseEvents(5'b00010);
		waitEdges(16);
		cpuRead(IST, d);
		compareValue("IST[4]", {31'd0, d[4]}, 32'd0);
		reportTest("timer 1");

		$display("checks: %0d, errors: %0d", checkCnt, errCnt);
		if (errCnt == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: tbClock.sv
module tbClock #(
	parameter int period = 40,
	parameter int resetCycles = 4
) (
	output logic CLK,
	output logic RST_N
);

	initial begin
		CLK = 1'b0;
		forever #(period / 2) CLK = ~CLK;
	end

	initial begin
		RST_N = 1'b0;
		repeat (resetCycles) @(posedge CLK);
		RST_N <= 1'b1;
	end

endmodule

// File: scuTop.sv
module scuTop import scuRegPkg::*, scuIrqPkg::*; #(
	parameter logic [24:0] regBase = 25'h1FE0000
) (
	input  logic        CLK,
	input  logic        RST_N,
	input  logic        CE_R,
	input  logic        CE_F,
	input  logic [24:0] CA,
	input  logic [31:0] CDI,
	input  logic [3:0]  CDQM_N,
	input  logic        CCS2_N,
	input  logic        CRD_N,
	input  logic        CIVECF_N,
	input  logic        IRQV_N,
	input  logic        IRQH_N,
	input  logic        IRQS_N,
	input  logic        IRQ1_N,
	input  logic        MIREQ_N,
	output logic [31:0] CDO,
	output logic [3:0]  CIRL_N
);

	cpuAccT     acc;
	extEvtT     evt;
	scuCfgT     cfg;
	logic       tm0Hit;
	logic       tm1Hit;
	irqSrcT     status;
	logic [7:0] vector;

	cpuBusPort #(.regBase(regBase)) cpuBusPort_i (
		.CLK(CLK), .RST_N(RST_N), .CE_R(CE_R), .CE_F(CE_F),
		.CA(CA), .CDI(CDI), .CDQM_N(CDQM_N), .CCS2_N(CCS2_N),
		.CRD_N(CRD_N), .CIVECF_N(CIVECF_N), .acc(acc)
	);

	extEventSampler extEventSampler_i (
		.CLK(CLK), .RST_N(RST_N), .CE_R(CE_R),
		.IRQV_N(IRQV_N), .IRQH_N(IRQH_N), .IRQS_N(IRQS_N),
		.IRQ1_N(IRQ1_N), .MIREQ_N(MIREQ_N), .evt(evt)
	);

	scuRegs scuRegs_i (.CLK(CLK), .RST_N(RST_N), .acc(acc), .cfg(cfg));

	scuTimers scuTimers_i (
		.CLK(CLK), .RST_N(RST_N), .CE_R(CE_R), .evt(evt), .cfg(cfg),
		.tm0Hit(tm0Hit), .tm1Hit(tm1Hit)
	);

	irqController irqController_i (
		.CLK(CLK), .RST_N(RST_N), .CE_R(CE_R), .CE_F(CE_F),
		.acc(acc), .evt(evt), .tm0Hit(tm0Hit), .tm1Hit(tm1Hit), .cfg(cfg),
		.status(status), .vector(vector), .CIRL_N(CIRL_N)
	);

	cpuReadPort cpuReadPort_i (
		.CLK(CLK), .RST_N(RST_N), .CE_R(CE_R), .CIVECF_N(CIVECF_N), .CRD_N(CRD_N),
		.acc(acc), .status(status), .vector(vector), .CDO(CDO)
	);

endmodule

// File: cpuReadPort.sv
module cpuReadPort import scuRegPkg::*, scuIrqPkg::*; (
	input  logic        CLK,
	input  logic        RST_N,
	input  logic        CE_R,
	input  logic        CIVECF_N,
	input  logic        CRD_N,
	input  cpuAccT      acc,
	input  irqSrcT      status,
	input  logic [7:0]  vector,
	output logic [31:0] CDO
);

	logic [31:0] regDo;
	logic [7:0]  vecDo;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			regDo <= '0;
			vecDo <= '0;
		end else begin
			// Only IST is readable here
			if (acc.rd)
				regDo <= (acc.off == IST_OFF) ? {16'd0, status} : '0;
			if (CE_R && !CIVECF_N && !CRD_N)
				vecDo <= vector;
		end
	end

	assign CDO = !CIVECF_N ? {24'd0, vecDo} : regDo;

endmodule

// File: irqController.sv
module irqController import scuRegPkg::*, scuIrqPkg::*; (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       CE_R,
	input  logic       CE_F,
	input  cpuAccT     acc,
	input  extEvtT     evt,
	input  logic       tm0Hit,
	input  logic       tm1Hit,
	input  scuCfgT     cfg,
	output irqSrcT     status,
	output logic [7:0] vector,
	output irqLevelT   CIRL_N
);

	irqSrcT      setSrc;
	irqSrcT      pend;
	logic [15:0] clrMask;
	logic [15:0] active;
	irqLevelT    topLvl;
	irqLevelT    lvl;
	logic        istWr;
	logic        vecFetch;

	assign istWr = CE_R & acc.wr & (acc.off == IST_OFF);
	assign vecFetch = CE_F & acc.vecRd;

	always_comb begin
		setSrc = '0;
		setSrc.vblankIn = evt.vblankIn;
		setSrc.vblankOut = evt.vblankOut;
		setSrc.hblankIn = evt.hblankIn;
		setSrc.timer0 = tm0Hit;
		setSrc.timer1 = tm1Hit;
		setSrc.sound = evt.soundReq;
		setSrc.sysMgr = evt.smReq;
		setSrc.spriteEnd = evt.spriteReq;
	end

	// IST write clears zero bits, vector fetch clears the served source
	always_comb begin
		clrMask = '0;
		if (istWr)
			clrMask = ~acc.data[15:0];
		if (vecFetch) begin
			for (int i = 0; i < NUM_SRC; i++) begin
				if (SRC_LEVEL[i] == acc.vecCode)
					clrMask[SRC_BIT[i]] = 1'b1;
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N)
			pend <= '0;
		else
			pend <= (pend | setSrc) & ~clrMask;
	end

	assign active = pend & ~cfg.ims;

	always_comb begin
		topLvl = LVL_NONE;
		for (int i = NUM_SRC - 1; i >= 0; i--) begin
			if (active[SRC_BIT[i]])
				topLvl = SRC_LEVEL[i];
		end
	end

	always_comb begin
		vector = '0;
		for (int i = 0; i < NUM_SRC; i++) begin
			if (SRC_LEVEL[i] == acc.vecCode)
				vector = SRC_VECTOR[i];
		end
	end

	// Level holds until the CPU acknowledges it
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			lvl <= LVL_NONE;
		end else if (lvl == LVL_NONE) begin
			if (CE_R)
				lvl <= topLvl;
		end else if (vecFetch || istWr) begin
			lvl <= LVL_NONE;
		end
	end

	assign status = pend;
	assign CIRL_N = ~lvl;

endmodule

// File: scuTimers.sv
module scuTimers import scuRegPkg::*, scuIrqPkg::*; (
	input  logic   CLK,
	input  logic   RST_N,
	input  logic   CE_R,
	input  extEvtT evt,
	input  scuCfgT cfg,
	output logic   tm0Hit,
	output logic   tm1Hit
);

	t0cT         tm0;
	logic [10:0] tm1;
	logic        occur;
	logic        run;

	assign run = CE_R & cfg.t1md.enb;

	// Match uses the count before this line's increment
	assign tm0Hit = run & evt.hblankIn & (tm0 == cfg.t0c);
	assign tm1Hit = run & (tm1 == '0) & occur;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			tm0 <= '0;
			tm1 <= '0;
			occur <= 1'b0;
		end else if (run) begin
			tm1 <= tm1 - 11'd1;
			if (tm1Hit)
				occur <= 1'b0;
			if (evt.hblankIn) begin
				tm0 <= tm0 + 10'd1;
				// Reload with T1S*4+3
				tm1 <= {cfg.t1s, 2'b11};
				if (!cfg.t1md.md || tm0Hit)
					occur <= 1'b1;
			end
			if (evt.vblankOut)
				tm0 <= '0;
		end
	end

endmodule

// File: scuRegs.sv
module scuRegs import scuRegPkg::*; (
	input  logic   CLK,
	input  logic   RST_N,
	input  cpuAccT acc,
	output scuCfgT cfg
);

	logic [31:0] t0cW;
	logic [31:0] t1sW;
	logic [31:0] t1mdW;
	logic [31:0] imsW;

	// Merge enabled bytes of the CPU data into the current value
	function automatic logic [31:0] byteWrite(input logic [31:0] cur, input cpuAccT a,
			input logic [31:0] wmask);
		logic [31:0] res;
		res = cur;
		for (int b = 0; b < 4; b++) begin
			if (a.be[b])
				res[b*8 +: 8] = a.data[b*8 +: 8] & wmask[b*8 +: 8];
		end
		return res;
	endfunction

	assign t0cW = byteWrite({22'd0, cfg.t0c}, acc, T0C_WMASK);
	assign t1sW = byteWrite({23'd0, cfg.t1s}, acc, T1S_WMASK);
	assign t1mdW = byteWrite({23'd0, cfg.t1md}, acc, T1MD_WMASK);
	assign imsW = byteWrite({16'd0, cfg.ims}, acc, IMS_WMASK);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cfg.t0c <= '0;
			cfg.t1s <= '0;
			cfg.t1md <= '0;
			cfg.ims <= IMS_RESET;
		end else if (acc.wr) begin
			case (acc.off)
				T0C_OFF:  cfg.t0c <= t0cW[9:0];
				T1S_OFF:  cfg.t1s <= t1sW[8:0];
				T1MD_OFF: cfg.t1md <= t1mdW[8:0];
				IMS_OFF:  cfg.ims <= imsW[15:0];
				default: ;
			endcase
		end
	end

endmodule

// File: extEventSampler.sv
module extEventSampler import scuIrqPkg::*; (
	input  logic   CLK,
	input  logic   RST_N,
	input  logic   CE_R,
	input  logic   IRQV_N,
	input  logic   IRQH_N,
	input  logic   IRQS_N,
	input  logic   IRQ1_N,
	input  logic   MIREQ_N,
	output extEvtT evt
);

	logic [4:0] lineNow;
	logic [4:0] lineOld;
	logic [4:0] fallEdge;

	assign lineNow = {MIREQ_N, IRQ1_N, IRQS_N, IRQH_N, IRQV_N};

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N)
			lineOld <= '1;
		else if (CE_R)
			lineOld <= lineNow;
	end

	assign fallEdge = {5{CE_R}} & lineOld & ~lineNow;

	always_comb begin
		evt.vblankIn = fallEdge[0];
		// V-blank end is the rising edge
		evt.vblankOut = CE_R & ~lineOld[0] & lineNow[0];
		evt.hblankIn = fallEdge[1];
		evt.soundReq = fallEdge[2];
		evt.spriteReq = fallEdge[3];
		evt.smReq = fallEdge[4];
	end

endmodule

// File: cpuBusPort.sv
module cpuBusPort import scuRegPkg::*; #(
	parameter logic [24:0] regBase = 25'h1FE0000
) (
	input  logic        CLK,
	input  logic        RST_N,
	input  logic        CE_R,
	input  logic        CE_F,
	input  logic [24:0] CA,
	input  logic [31:0] CDI,
	input  logic [3:0]  CDQM_N,
	input  logic        CCS2_N,
	input  logic        CRD_N,
	input  logic        CIVECF_N,
	output cpuAccT      acc
);

	logic        dqmOffOld;
	logic        rdNOld;
	logic [24:0] winOff;
	logic        inWin;
	logic        cwe;
	logic        cre;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			dqmOffOld <= 1'b1;
			rdNOld <= 1'b1;
		end else begin
			if (CE_R)
				dqmOffOld <= &CDQM_N;
			if (CE_F)
				rdNOld <= CRD_N;
		end
	end

	// Write on first byte enable, read on CRD_N fall
	assign cwe = CE_R & dqmOffOld & ~&CDQM_N;
	assign cre = CE_F & rdNOld & ~CRD_N;

	assign winOff = CA - regBase;
	assign inWin = ~CCS2_N & (CA >= regBase) & (winOff <= 25'h00000CF);

	always_comb begin
		acc.wr = inWin & cwe;
		acc.rd = inWin & cre;
		acc.vecRd = ~CIVECF_N & cre;
		acc.off = {winOff[7:2], 2'b00};
		acc.vecCode = CA[3:0];
		acc.be = ~CDQM_N;
		acc.data = CDI;
	end

endmodule

// File: scuIrqPkg.sv
package scuIrqPkg;

	// Same layout as the IST register
	typedef struct packed {
		logic [1:0] rsv14;
		logic       spriteEnd;
		logic [4:0] rsv8;
		logic       sysMgr;
		logic       sound;
		logic       rsv5;
		logic       timer1;
		logic       timer0;
		logic       hblankIn;
		logic       vblankOut;
		logic       vblankIn;
	} irqSrcT;

	typedef struct packed {
		logic vblankIn;
		logic vblankOut;
		logic hblankIn;
		logic soundReq;
		logic spriteReq;
		logic smReq;
	} extEvtT;

	typedef logic [3:0] irqLevelT;

	localparam irqLevelT LVL_NONE = 4'd0;

	// Sources in priority order, highest first
	localparam int NUM_SRC = 8;
	localparam logic [3:0] SRC_BIT [NUM_SRC] = '{4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd6, 4'd7, 4'd13};
	localparam irqLevelT SRC_LEVEL [NUM_SRC] =
		'{4'd15, 4'd14, 4'd13, 4'd12, 4'd11, 4'd9, 4'd8, 4'd2};
	localparam logic [7:0] SRC_VECTOR [NUM_SRC] =
		'{8'h40, 8'h41, 8'h42, 8'h43, 8'h44, 8'h46, 8'h47, 8'h4D};

endpackage

// File: scuRegPkg.sv
package scuRegPkg;

	typedef logic [7:0] regOffT;

	// Word offsets inside the register window
	localparam regOffT T0C_OFF  = 8'h90;
	localparam regOffT T1S_OFF  = 8'h94;
	localparam regOffT T1MD_OFF = 8'h98;
	localparam regOffT IMS_OFF  = 8'hA0;
	localparam regOffT IST_OFF  = 8'hA4;

	typedef logic [9:0] t0cT;
	typedef logic [8:0] t1sT;

	typedef struct packed {
		logic       md;
		logic [6:0] rsv;
		logic       enb;
	} t1mdT;

	// A set bit masks the source at the same status position
	typedef logic [15:0] imsT;

	localparam imsT IMS_RESET = 16'hBFFF;

	localparam logic [31:0] T0C_WMASK  = 32'h0000_03FF;
	localparam logic [31:0] T1S_WMASK  = 32'h0000_01FF;
	localparam logic [31:0] T1MD_WMASK = 32'h0000_0101;
	localparam logic [31:0] IMS_WMASK  = 32'h0000_BFFF;

	typedef struct packed {
		logic        wr;
		logic        rd;
		logic        vecRd;
		regOffT      off;
		logic [3:0]  vecCode;
		logic [3:0]  be;
		logic [31:0] data;
	} cpuAccT;

	typedef struct packed {
		t0cT  t0c;
		t1sT  t1s;
		t1mdT t1md;
		imsT  ims;
	} scuCfgT;

endpackage
